// ==== Makefile ====
# Verilator build and run for the texture generator testbench

VERILATOR ?= verilator
TOP       ?= tb_texgen
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Regression passed
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== delay_line.sv ====
module delay_line
#(
	parameter int DEPTH = 4,
	parameter type payload_t = logic [15:0]
)
(
	input  logic     clk,
	input  logic     rst,
	input  logic     en,
	input  payload_t d,
	output payload_t q
);

	// stage 0 takes d, the last stage drives q
	payload_t pipe [DEPTH];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < DEPTH; i++)
				pipe[i] <= '0;
		end
		else if (en)
		begin
			pipe[0] <= d;
			// shift the rest by one stage
			for (int i = 1; i < DEPTH; i++)
				pipe[i] <= pipe[i - 1];
		end
	end

	assign q = pipe[DEPTH - 1];

endmodule

// ==== pseudo_sin.sv ====
module pseudo_sin
	import texgen_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic               en,
	input  coord_t             phase,
	output logic signed [31:0] s,
	output region_t            region
);

	// fold the low half of the phase around the half-scale point
	logic signed [31:0] folded;
	logic signed [31:0] mag;
	logic signed [31:0] xc;

	// stage 1 registers
	logic signed [31:0] x1;
	logic signed [31:0] x2;
	logic               sgn1;
	region_t            rgn1;

	// stage 2 registers
	logic signed [31:0] x2d;
	logic signed [31:0] x3;
	logic               sgn2;
	region_t            rgn2;

	// smoothstep 3x^2 - 2x^3 taken from one half
	logic signed [31:0] poly;

	assign folded = PSIN_HALF - {16'b0, phase[15:0]};
	assign mag = (folded < 0) ? -folded : folded;
	// keep the polynomial off the flat spot near zero
	assign xc = (mag < PSIN_MIN_MAG) ? PSIN_MIN_MAG : folded;
	assign poly = PSIN_ONE - (3 * x2d - 2 * x3);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			x1 <= '0;
			x2 <= '0;
			sgn1 <= 1'b0;
			rgn1 <= '0;
			x2d <= '0;
			x3 <= '0;
			sgn2 <= 1'b0;
			rgn2 <= '0;
			s <= '0;
			region <= '0;
		end
		else if (en)
		begin
			// stage 1 magnitude and square
			x1 <= (xc < 0) ? -xc : xc;
			x2 <= (xc * xc) >>> 16;
			sgn1 <= phase[16];
			rgn1 <= phase[31:16];
			// stage 2 cube, square held one more cycle
			x2d <= x2;
			x3 <= (x1 * x2) >>> 16;
			sgn2 <= sgn1;
			rgn2 <= rgn1;
			// stage 3 doubled, negated on odd half periods
			s <= sgn2 ? -(poly <<< 1) : (poly <<< 1);
			region <= rgn2;
		end
	end

endmodule

// ==== psin_texture.sv ====
module psin_texture
	import texgen_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   en,
	input  pixel_t pix,
	output texel_t texel
);

	// first rank outputs
	logic signed [31:0] sx;
	logic signed [31:0] sy;
	region_t            rx;
	region_t            ry;

	// product stage register
	logic signed [31:0] sxsy;

	// second rank output
	logic signed [31:0] sv;

	// period indices lined up with sv
	region_t            rxd;
	region_t            ryd;

	// packing inputs
	region_t            rsum;
	region_t            rdiff;
	region_t            sel;
	logic signed [31:0] sv_mag;
	logic [7:0]         nib_prod;
	texel_t             packed_texel;

	// both axes run at eight times the pixel rate
	pseudo_sin sin_x (
		.clk    (clk),
		.rst    (rst),
		.en     (en),
		.phase  (pix.x <<< 3),
		.s      (sx),
		.region (rx)
	);

	pseudo_sin sin_y (
		.clk    (clk),
		.rst    (rst),
		.en     (en),
		.phase  (pix.y <<< 3),
		.s      (sy),
		.region (ry)
	);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			sxsy <= '0;
		else if (en)
			// scale both down to keep the product inside 32 bits
			sxsy <= ((sx >>> 7) * (sy >>> 7)) / 2;
	end

	// only the value of the second rank feeds the texel
	pseudo_sin sin_v (
		.clk    (clk),
		.rst    (rst),
		.en     (en),
		.phase  (sxsy <<< 1),
		.s      (sv),
		.region ()
	);

	// product stage plus the sin_v stages
	delay_line #(.DEPTH(PSIN_DEPTH + 1), .payload_t(region_t)) rx_delay (
		.clk (clk),
		.rst (rst),
		.en  (en),
		.d   (rx),
		.q   (rxd)
	);

	delay_line #(.DEPTH(PSIN_DEPTH + 1), .payload_t(region_t)) ry_delay (
		.clk (clk),
		.rst (rst),
		.en  (en),
		.d   (ry),
		.q   (ryd)
	);

	assign rsum = rxd + ryd;
	assign rdiff = rxd - ryd;
	// sum on the positive lobe of sv, difference otherwise
	assign sel = (sv > 0) ? rsum : rdiff;
	assign sv_mag = (sv > 0) ? sv : -sv;
	assign nib_prod = sel[3:0] * sel[7:4];
	// cells with bit 3 clear stay black
	assign packed_texel = sel[3] ? {sel[3:0], 4'b0, nib_prod, sv_mag[15:0]} : '0;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			texel <= '0;
		else if (en)
			texel <= packed_texel;
	end

endmodule

// ==== raster_scan.sv ====
module raster_scan
	import texgen_pkg::*;
#(
	parameter int MAX_DIM = 12
)
(
	input  logic       clk,
	input  logic       rst,
	input  logic       cmd_valid,
	output logic       cmd_ready,
	input  frame_cmd_t cmd,
	input  logic       en,
	output logic       pix_valid,
	output pixel_t     pix,
	output marks_t     marks
);

	// command held for the whole frame
	frame_cmd_t cmd_q;

	// high from accept until the last pixel is registered
	logic busy;

	logic [MAX_DIM-1:0] col;
	logic [MAX_DIM-1:0] row;
	logic [MAX_DIM-1:0] col_last;
	logic [MAX_DIM-1:0] row_last;
	logic               at_col_end;
	logic               at_row_end;

	assign cmd_ready = !busy;

	assign col_last = MAX_DIM'(cmd_q.width) - 1'b1;
	assign row_last = MAX_DIM'(cmd_q.height) - 1'b1;
	assign at_col_end = (col == col_last);
	assign at_row_end = (row == row_last);

	always_ff @(posedge clk)
	begin
		if (cmd_valid && cmd_ready)
			cmd_q <= cmd;
	end

	// FSM and counters
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			col <= '0;
			row <= '0;
			pix_valid <= 1'b0;
		end
		else if (!busy)
		begin
			if (cmd_valid)
			begin
				busy <= 1'b1;
				col <= '0;
				row <= '0;
			end
			// a stalled last pixel stays valid until it moves on
			if (en)
				pix_valid <= 1'b0;
		end
		else if (en)
		begin
			pix_valid <= 1'b1;
			if (at_col_end)
			begin
				col <= '0;
				if (at_row_end)
				begin
					busy <= 1'b0;
					row <= '0;
				end
				else
					row <= row + 1'b1;
			end
			else
				col <= col + 1'b1;
		end
	end

	// pixel register, loaded once per advancing edge of a frame
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			pix <= '0;
			marks <= '0;
		end
		else if (en && busy)
		begin
			// scroll is in whole pixels, added before the shift
			pix.x <= (coord_t'(col) + coord_t'(cmd_q.scroll)) <<< FRAC_BITS;
			pix.y <= coord_t'(row) <<< FRAC_BITS;
			marks.line_end <= at_col_end;
			marks.frame_end <= at_col_end && at_row_end;
		end
	end

endmodule

// ==== sim.f ====
texgen_pkg.sv
delay_line.sv
pseudo_sin.sv
psin_texture.sv
raster_scan.sv
texgen_top.sv
tb_texgen.sv

// ==== tb_texgen.sv ====
module tb_texgen
	import texgen_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	logic       clk;
	logic       rst;
	logic       cmd_valid;
	logic       cmd_ready;
	frame_cmd_t cmd;
	logic       tex_valid;
	logic       tex_ready;
	texel_out_t tex;

	// frame commands and expected texel stream from the pattern file
	frame_cmd_t frames[$];
	texel_t     exp_val[$];
	marks_t     exp_marks[$];
	int         total_pix = 0;
	bit         loaded = 1'b0;

	// back-pressure switch, off for the first frame
	bit         bp_on = 1'b0;
	integer     seed = 99;

	// receive side bookkeeping
	int         rx_idx = 0;
	int         frames_done = 0;
	int         frame_cnt = 0;
	bit         stalled_prev = 1'b0;
	texel_out_t held;

	// command side bookkeeping
	int         acc_idx = 0;
	int         scan_left = 0;

	texgen_top #(.MAX_DIM(12)) UUT (
		.clk       (clk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd       (cmd),
		.tex_valid (tex_valid),
		.tex_ready (tex_ready),
		.tex       (tex)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input texel_t got, input texel_t exp);
		if (got !== exp)
			fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_marks(input string name, input marks_t got, input marks_t exp);
		if (got !== exp)
			fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			fail_now($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	function automatic int pixels_in_frame(input int idx);
		return int'(frames[idx].width) * int'(frames[idx].height);
	endfunction

	// C lines hold a command, T lines one expected texel with its flags
	task automatic load_patterns();
		int         fd;
		int         r;
		string      tag;
		string      rest;
		int         w;
		int         h;
		int         s;
		logic [31:0] v;
		int         le;
		int         fe;
		frame_cmd_t c;
		marks_t     m;
		fd = $fopen("texgen_patterns.txt", "r");
		if (fd == 0)
			fail_now("cannot open texgen_patterns.txt");
		while (!$feof(fd))
		begin
			r = $fscanf(fd, "%s", tag);
			if (r != 1)
				break;
			if (tag.getc(0) == "#")
				r = $fgets(rest, fd);
			else if (tag == "C")
			begin
				r = $fscanf(fd, "%d %d %d", w, h, s);
				if (r != 3)
					fail_now("bad command line in the pattern file");
				c.width = 12'(w);
				c.height = 12'(h);
				c.scroll = 16'(s);
				frames.push_back(c);
				total_pix += w * h;
			end
			else if (tag == "T")
			begin
				r = $fscanf(fd, "%h %d %d", v, le, fe);
				if (r != 3)
					fail_now("bad texel line in the pattern file");
				m.line_end = le[0];
				m.frame_end = fe[0];
				exp_val.push_back(v);
				exp_marks.push_back(m);
			end
			else
				fail_now($sformatf("unknown tag %s in the pattern file", tag));
		end
		$fclose(fd);
		if (frames.size() == 0 || exp_val.size() != total_pix)
			fail_now("pattern file texel lines do not match its frame commands");
	endtask

	// returns on the edge where the offered command is taken
	task automatic wait_accept();
		@(posedge clk);
		while (cmd_ready !== 1'b1)
			@(posedge clk);
	endtask

	// sink, random stalls about a third of the time
	initial
	begin
		tex_ready = 1'b1;
		forever
		begin
			@(posedge clk);
			#1;
			if (bp_on)
				tex_ready = ($unsigned($random(seed)) % 3) != 0;
			else
				tex_ready = 1'b1;
		end
	end

	// output stream and command rules, sampled at the edge
	always @(posedge clk)
	begin
		logic adv;
		if (!rst)
		begin
			adv = !tex_valid || tex_ready;
			// a stalled texel must stay put
			if (stalled_prev)
			begin
				if (tex_valid !== 1'b1)
					fail_now("tex_valid dropped while the sink was stalling");
				check_value("tex.value held", tex.value, held.value);
				check_marks("tex.marks held", tex.marks, held.marks);
			end
			if (tex_valid && tex_ready)
			begin
				if (rx_idx >= exp_val.size())
					fail_now("a texel arrived beyond the expected stream");
				check_value("tex.value", tex.value, exp_val[rx_idx]);
				check_marks("tex.marks", tex.marks, exp_marks[rx_idx]);
				rx_idx++;
				frame_cnt++;
				if (tex.marks.frame_end)
				begin
					check_count("frame texel count", frame_cnt, pixels_in_frame(frames_done));
					frames_done++;
					frame_cnt = 0;
				end
			end
			stalled_prev = tex_valid && !tex_ready;
			held = tex;
			// one pixel per advancing edge, no new command until all are out
			if (cmd_valid && cmd_ready)
			begin
				if (scan_left != 0)
					fail_now("a command was accepted while a frame was still being scanned");
				scan_left = pixels_in_frame(acc_idx);
				acc_idx++;
			end
			else if (scan_left > 0)
			begin
				if (cmd_ready)
					fail_now("cmd_ready went high while a frame was being scanned");
				if (adv)
					scan_left--;
			end
		end
	end

	initial
	begin
		int limit;
		wait (loaded);
		limit = 40 * total_pix + 200;
		repeat (limit) @(posedge clk);
		fail_now($sformatf("no texel arrived in time, run stopped after %0d cycles", limit));
	end

	initial
	begin
		int cycles;
		int k;
		rst = 1'b1;
		cmd_valid = 1'b0;
		cmd = '0;
		load_patterns();
		loaded = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		if (tex_valid !== 1'b0)
			fail_now("tex_valid is high after reset");
		if (cmd_ready !== 1'b1)
			fail_now("cmd_ready is low after reset");
		// first frame without stalls, measure the latency
		cmd_valid = 1'b1;
		cmd = frames[0];
		wait_accept();
		#1;
		cmd_valid = 1'b0;
		cycles = 0;
		do
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		while (!tex_valid && cycles < 40);
		check_count("first texel latency", cycles, 9);
		wait (frames_done == 1);
		bp_on = 1'b1;
		@(posedge clk);
		#1;
		// later commands are offered as soon as the previous one is taken
		for (k = 1; k < frames.size(); k++)
		begin
			cmd_valid = 1'b1;
			cmd = frames[k];
			wait_accept();
			#1;
		end
		cmd_valid = 1'b0;
		wait (frames_done == frames.size());
		// give a stray texel time to reach the output
		repeat (TEX_LATENCY + 4) @(posedge clk);
		#1;
		if (tex_valid === 1'b0 && cmd_ready === 1'b1)
		begin
			$display("Regression passed");
			$finish;
		end
		else
			fail_now("the DUT did not drain after the last frame");
	end

endmodule

// ==== texgen_patterns.txt ====
# C width height scroll (decimal)
# T texel_hex line_end frame_end, in row-major order
# frame 0, scroll 0 keeps every region at zero so all texels are black
C 3 1 0
T 00000000 0 0
T 00000000 0 0
T 00000000 1 1
# frame 1, region 8 on the sum branch
C 2 2 256
T 80000002 0 0
T 80000002 1 0
T 80000002 0 0
T 800019da 1 1
# frame 2, region 27 with odd half periods, second row takes the difference branch
C 2 2 864
T b00b0002 0 0
T b00b0002 1 0
T b00b0086 0 0
T b00b1a64 1 1

// ==== texgen_pkg.sv ====
package texgen_pkg;

	// pixel coordinates carry 8 fractional bits below the pixel index
	localparam int FRAC_BITS = 8;

	// register stages inside one pseudo-sine unit
	localparam int PSIN_DEPTH = 3;

	// two pseudo-sine units in series plus the product and packing stages
	localparam int TEX_LATENCY = 2 * PSIN_DEPTH + 2;

	// fold point of the 16-bit phase
	localparam logic signed [31:0] PSIN_HALF = 32'sh0000_7fff;

	// smallest folded magnitude fed to the polynomial
	localparam logic signed [31:0] PSIN_MIN_MAG = 32'sd256;

	// 0.5 in the q16 scale of the cubic
	localparam logic signed [31:0] PSIN_ONE = 32'sd32768;

	// signed fixed-point pixel coordinate
	typedef logic signed [31:0] coord_t;

	// period index, the integer part of a phase
	typedef logic [15:0] region_t;

	// frame command as it arrives on the command stream
	typedef struct packed {
		logic [11:0] width;
		logic [11:0] height;
		logic [15:0] scroll;
	} frame_cmd_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} pixel_t;

	// sideband flags that ride alongside each pixel
	typedef struct packed {
		logic line_end;
		logic frame_end;
	} marks_t;

	typedef logic [31:0] texel_t;

	typedef struct packed {
		texel_t value;
		marks_t marks;
	} texel_out_t;

endpackage

// ==== texgen_top.sv ====
module texgen_top
	import texgen_pkg::*;
#(
	parameter int MAX_DIM = 12
)
(
	input  logic       clk,
	input  logic       rst,
	input  logic       cmd_valid,
	output logic       cmd_ready,
	input  frame_cmd_t cmd,
	output logic       tex_valid,
	input  logic       tex_ready,
	output texel_out_t tex
);

	// valid bit and flags that follow each pixel through the texture
	typedef struct packed {
		logic   valid;
		marks_t marks;
	} side_t;

	// one enable for every pipeline register
	logic   advance;

	logic   pix_valid;
	pixel_t pix;
	marks_t marks;
	texel_t texel;
	side_t  side_d;
	side_t  side_q;

	// move when the output slot is empty or being taken
	assign advance = !tex_valid || tex_ready;

	raster_scan #(.MAX_DIM(MAX_DIM)) u_scan (
		.clk       (clk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd_ready (cmd_ready),
		.cmd       (cmd),
		.en        (advance),
		.pix_valid (pix_valid),
		.pix       (pix),
		.marks     (marks)
	);

	psin_texture u_tex (
		.clk   (clk),
		.rst   (rst),
		.en    (advance),
		.pix   (pix),
		.texel (texel)
	);

	assign side_d = '{valid: pix_valid, marks: marks};

	// matches the texture latency so flags land with their texel
	delay_line #(.DEPTH(TEX_LATENCY), .payload_t(side_t)) u_side (
		.clk (clk),
		.rst (rst),
		.en  (advance),
		.d   (side_d),
		.q   (side_q)
	);

	// last delay stage and the texel register form the output slot
	assign tex_valid = side_q.valid;
	assign tex = '{value: texel, marks: side_q.marks};

endmodule
